// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes kept by this core
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_system = 7'b1110011;

  // funct7_alt turns add into sub and srl into sra
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  localparam logic [2:0] funct3_beq  = 3'b000;
  localparam logic [2:0] funct3_bne  = 3'b001;
  localparam logic [2:0] funct3_blt  = 3'b100;
  localparam logic [2:0] funct3_bge  = 3'b101;
  localparam logic [2:0] funct3_bltu = 3'b110;
  localparam logic [2:0] funct3_bgeu = 3'b111;

  localparam word_t insn_ecall = 32'h0000_0073;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fields_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fields_t;

  // same word seen as register-register or register-immediate form
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } rv_insn_u;

endpackage

// ==== source/pipe_pkg.sv ====
package pipe_pkg;

  // one-hot status of the cycle seen at writeback
  typedef enum logic [3:0] {
    cycle_reset        = 4'd1,
    cycle_no_stall     = 4'd2,
    cycle_taken_branch = 4'd4
  } cycle_status_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

endpackage

// ==== source/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 we,
  input  rv_isa_pkg::reg_idx_t rd,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  input  rv_isa_pkg::word_t    rd_data,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data
);

  // x0 has no storage
  rv_isa_pkg::word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign rs1_data = (rs1 == 5'd0) ? '0 :
                    (we && rd == rs1) ? rd_data : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 :
                    (we && rd == rs2) ? rd_data : regs[rs2];

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    redirect,
  input  rv_isa_pkg::word_t       target,
  output rv_isa_pkg::word_t       pc,
  output rv_isa_pkg::word_t       pc_d,
  output pipe_pkg::cycle_status_e status_d
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc       <= reset_pc;
      pc_d     <= '0;
      status_d <= pipe_pkg::cycle_reset;
    end else if (redirect) begin
      pc       <= target;
      // word in flight comes from the wrong path
      pc_d     <= '0;
      status_d <= pipe_pkg::cycle_taken_branch;
    end else begin
      pc       <= pc + 32'd4;
      // memory answers for this pc at the same edge
      pc_d     <= pc;
      status_d <= pipe_pkg::cycle_no_stall;
    end
  end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_isa_pkg::word_t       insn,
  input  rv_isa_pkg::word_t       pc_d,
  input  pipe_pkg::cycle_status_e status_d,
  input  logic                    redirect,
  input  rv_isa_pkg::word_t       rs1_data,
  input  rv_isa_pkg::word_t       rs2_data,
  output rv_isa_pkg::reg_idx_t    rs1,
  output rv_isa_pkg::reg_idx_t    rs2,
  output rv_isa_pkg::word_t       x_pc,
  output rv_isa_pkg::word_t       x_insn,
  output rv_isa_pkg::word_t       x_op_a,
  output rv_isa_pkg::word_t       x_op_b,
  output rv_isa_pkg::word_t       x_rs2_val,
  output rv_isa_pkg::word_t       x_target,
  output rv_isa_pkg::reg_idx_t    x_rs1,
  output rv_isa_pkg::reg_idx_t    x_rs2,
  output rv_isa_pkg::reg_idx_t    x_rd,
  output logic                    x_use_imm,
  output logic                    x_we,
  output logic                    x_branch,
  output logic                    x_jal,
  output logic                    x_ecall,
  output logic [2:0]              x_funct3,
  output pipe_pkg::alu_op_e       x_op,
  output pipe_pkg::cycle_status_e x_status
);

  rv_isa_pkg::rv_insn_u d_insn;
  rv_isa_pkg::word_t    imm_i, imm_u, imm_b, imm_j;
  rv_isa_pkg::word_t    op_b, target;
  pipe_pkg::alu_op_e    op;
  logic                 alt, use_imm, we, branch, jal, ecall;

  assign d_insn = insn;
  assign rs1    = d_insn.r.rs1;
  assign rs2    = d_insn.r.rs2;
  assign alt    = d_insn.r.funct7 == rv_isa_pkg::funct7_alt;

  assign imm_i = {{20{d_insn.i.imm12[11]}}, d_insn.i.imm12};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

  // both jump kinds are pc relative
  assign target = pc_d + (d_insn.r.opcode == rv_isa_pkg::opcode_jal ? imm_j : imm_b);
  assign op_b   = d_insn.r.opcode == rv_isa_pkg::opcode_lui ? imm_u : imm_i;

  always_comb begin
    use_imm = 1'b0;
    we      = 1'b0;
    branch  = 1'b0;
    jal     = 1'b0;
    ecall   = 1'b0;
    case (d_insn.r.funct3)
      3'b000: op = (d_insn.r.opcode == rv_isa_pkg::opcode_op && alt) ?
                   pipe_pkg::alu_sub : pipe_pkg::alu_add;
      3'b001: op = pipe_pkg::alu_sll;
      3'b010: op = pipe_pkg::alu_slt;
      3'b011: op = pipe_pkg::alu_sltu;
      3'b100: op = pipe_pkg::alu_xor;
      3'b101: op = alt ? pipe_pkg::alu_sra : pipe_pkg::alu_srl;
      3'b110: op = pipe_pkg::alu_or;
      default: op = pipe_pkg::alu_and;
    endcase
    case (d_insn.r.opcode)
      rv_isa_pkg::opcode_op: begin
        we = alt || d_insn.r.funct7 == rv_isa_pkg::funct7_base;
      end
      rv_isa_pkg::opcode_op_imm: begin
        we      = 1'b1;
        use_imm = 1'b1;
      end
      rv_isa_pkg::opcode_lui: begin
        we      = 1'b1;
        use_imm = 1'b1;
        op      = pipe_pkg::alu_pass_b;
      end
      rv_isa_pkg::opcode_jal: begin
        we  = 1'b1;
        jal = 1'b1;
      end
      rv_isa_pkg::opcode_branch: branch = 1'b1;
      rv_isa_pkg::opcode_system: ecall = insn == rv_isa_pkg::insn_ecall;
      default: ;
    endcase
  end

  // flags and trace fields, cleared for bubbles
  always_ff @(posedge clk) begin
    if (rst) begin
      x_pc     <= '0;
      x_insn   <= '0;
      x_we     <= 1'b0;
      x_branch <= 1'b0;
      x_jal    <= 1'b0;
      x_ecall  <= 1'b0;
      x_status <= pipe_pkg::cycle_reset;
    end else if (redirect || status_d != pipe_pkg::cycle_no_stall) begin
      x_pc     <= '0;
      x_insn   <= '0;
      x_we     <= 1'b0;
      x_branch <= 1'b0;
      x_jal    <= 1'b0;
      x_ecall  <= 1'b0;
      x_status <= redirect ? pipe_pkg::cycle_taken_branch : status_d;
    end else begin
      x_pc     <= pc_d;
      x_insn   <= insn;
      x_we     <= we && d_insn.r.rd != 5'd0;
      x_branch <= branch;
      x_jal    <= jal;
      x_ecall  <= ecall;
      x_status <= status_d;
    end
  end

  always_ff @(posedge clk) begin
    x_op_a    <= rs1_data;
    x_op_b    <= op_b;
    x_rs2_val <= rs2_data;
    x_target  <= target;
    x_rs1     <= d_insn.r.rs1;
    x_rs2     <= d_insn.r.rs2;
    x_rd      <= d_insn.r.rd;
    x_use_imm <= use_imm;
    x_funct3  <= d_insn.r.funct3;
    x_op      <= op;
  end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/100ps

module alu (
  input  pipe_pkg::alu_op_e op,
  input  rv_isa_pkg::word_t a,
  input  rv_isa_pkg::word_t b,
  output rv_isa_pkg::word_t result
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  // only the low five bits shift in RV32
  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      pipe_pkg::alu_add:    result = a + b;
      pipe_pkg::alu_sub:    result = a - b;
      pipe_pkg::alu_sll:    result = a << shamt;
      pipe_pkg::alu_slt:    result = {31'b0, lt_s};
      pipe_pkg::alu_sltu:   result = {31'b0, lt_u};
      pipe_pkg::alu_xor:    result = a ^ b;
      pipe_pkg::alu_srl:    result = a >> shamt;
      pipe_pkg::alu_sra:    result = $signed(a) >>> shamt;
      pipe_pkg::alu_or:     result = a | b;
      pipe_pkg::alu_and:    result = a & b;
      // lui hands its upper immediate straight through
      pipe_pkg::alu_pass_b: result = b;
      default:              result = '0;
    endcase
  end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_isa_pkg::word_t       x_pc,
  input  rv_isa_pkg::word_t       x_insn,
  input  rv_isa_pkg::word_t       x_op_a,
  input  rv_isa_pkg::word_t       x_op_b,
  input  rv_isa_pkg::word_t       x_rs2_val,
  input  rv_isa_pkg::word_t       x_target,
  input  rv_isa_pkg::reg_idx_t    x_rs1,
  input  rv_isa_pkg::reg_idx_t    x_rs2,
  input  rv_isa_pkg::reg_idx_t    x_rd,
  input  logic                    x_use_imm,
  input  logic                    x_we,
  input  logic                    x_branch,
  input  logic                    x_jal,
  input  logic                    x_ecall,
  input  logic [2:0]              x_funct3,
  input  pipe_pkg::alu_op_e       x_op,
  input  pipe_pkg::cycle_status_e x_status,
  input  logic                    wb_we,
  input  rv_isa_pkg::reg_idx_t    wb_rd,
  input  rv_isa_pkg::word_t       wb_data,
  output logic                    redirect,
  output rv_isa_pkg::word_t       target,
  output rv_isa_pkg::word_t       trace_pc,
  output rv_isa_pkg::word_t       trace_insn,
  output pipe_pkg::cycle_status_e trace_status,
  output logic                    halt,
  output logic                    wb_we_q,
  output rv_isa_pkg::reg_idx_t    wb_rd_q,
  output rv_isa_pkg::word_t       wb_data_q
);

  rv_isa_pkg::word_t rs1_val, rs2_val, alu_b, alu_result, result;
  logic              eq, lt_s, lt_u, taken;

  // the instruction just ahead is in writeback and not yet in the register file
  assign rs1_val = (wb_we && wb_rd == x_rs1 && x_rs1 != 5'd0) ? wb_data : x_op_a;
  assign rs2_val = (wb_we && wb_rd == x_rs2 && x_rs2 != 5'd0) ? wb_data : x_rs2_val;
  assign alu_b   = x_use_imm ? x_op_b : rs2_val;

  alu u_alu (
    .op     (x_op),
    .a      (rs1_val),
    .b      (alu_b),
    .result (alu_result)
  );

  assign eq   = rs1_val == rs2_val;
  assign lt_s = $signed(rs1_val) < $signed(rs2_val);
  assign lt_u = rs1_val < rs2_val;

  always_comb begin
    case (x_funct3)
      rv_isa_pkg::funct3_beq:  taken = eq;
      rv_isa_pkg::funct3_bne:  taken = !eq;
      rv_isa_pkg::funct3_blt:  taken = lt_s;
      rv_isa_pkg::funct3_bge:  taken = !lt_s;
      rv_isa_pkg::funct3_bltu: taken = lt_u;
      rv_isa_pkg::funct3_bgeu: taken = !lt_u;
      default:                 taken = 1'b0;
    endcase
  end

  // single-cycle pulse, bubbles carry no branch or jal flag
  assign redirect = x_jal || (x_branch && taken);
  assign target   = x_target;

  // link value for jal
  assign result = x_jal ? x_pc + 32'd4 : alu_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_we_q      <= 1'b0;
      halt         <= 1'b0;
      trace_pc     <= '0;
      trace_insn   <= '0;
      trace_status <= pipe_pkg::cycle_reset;
    end else begin
      wb_we_q      <= x_we;
      halt         <= x_ecall;
      trace_pc     <= x_pc;
      trace_insn   <= x_insn;
      trace_status <= x_status;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_q   <= x_rd;
    wb_data_q <= result;
  end

endmodule

// ==== source/riscv_pipeline.sv ====
`timescale 1ns/100ps

module riscv_pipeline #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_isa_pkg::word_t       insn,
  output rv_isa_pkg::word_t       pc,
  output logic                    halt,
  output rv_isa_pkg::word_t       trace_pc,
  output rv_isa_pkg::word_t       trace_insn,
  output pipe_pkg::cycle_status_e trace_status,
  output logic                    wb_we,
  output rv_isa_pkg::reg_idx_t    wb_rd,
  output rv_isa_pkg::word_t       wb_data
);

  // fetch to decode
  rv_isa_pkg::word_t       pc_d;
  pipe_pkg::cycle_status_e status_d;

  // register file read side
  rv_isa_pkg::reg_idx_t    rs1, rs2;
  rv_isa_pkg::word_t       rs1_data, rs2_data;

  // decode to execute
  rv_isa_pkg::word_t       x_pc, x_insn, x_op_a, x_op_b, x_rs2_val, x_target;
  rv_isa_pkg::reg_idx_t    x_rs1, x_rs2, x_rd;
  logic                    x_use_imm, x_we, x_branch, x_jal, x_ecall;
  logic [2:0]              x_funct3;
  pipe_pkg::alu_op_e       x_op;
  pipe_pkg::cycle_status_e x_status;

  // execute back to the front end
  logic                    redirect;
  rv_isa_pkg::word_t       target;

  fetch_stage #(
    .reset_pc (reset_pc)
  ) u_fetch (
    .clk      (clk),
    .rst      (rst),
    .redirect (redirect),
    .target   (target),
    .pc       (pc),
    .pc_d     (pc_d),
    .status_d (status_d)
  );

  decode_stage u_decode (
    .clk       (clk),
    .rst       (rst),
    .insn      (insn),
    .pc_d      (pc_d),
    .status_d  (status_d),
    .redirect  (redirect),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .rs1       (rs1),
    .rs2       (rs2),
    .x_pc      (x_pc),
    .x_insn    (x_insn),
    .x_op_a    (x_op_a),
    .x_op_b    (x_op_b),
    .x_rs2_val (x_rs2_val),
    .x_target  (x_target),
    .x_rs1     (x_rs1),
    .x_rs2     (x_rs2),
    .x_rd      (x_rd),
    .x_use_imm (x_use_imm),
    .x_we      (x_we),
    .x_branch  (x_branch),
    .x_jal     (x_jal),
    .x_ecall   (x_ecall),
    .x_funct3  (x_funct3),
    .x_op      (x_op),
    .x_status  (x_status)
  );

  // written from writeback, read by decode
  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .we       (wb_we),
    .rd       (wb_rd),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  execute_stage u_execute (
    .clk          (clk),
    .rst          (rst),
    .x_pc         (x_pc),
    .x_insn       (x_insn),
    .x_op_a       (x_op_a),
    .x_op_b       (x_op_b),
    .x_rs2_val    (x_rs2_val),
    .x_target     (x_target),
    .x_rs1        (x_rs1),
    .x_rs2        (x_rs2),
    .x_rd         (x_rd),
    .x_use_imm    (x_use_imm),
    .x_we         (x_we),
    .x_branch     (x_branch),
    .x_jal        (x_jal),
    .x_ecall      (x_ecall),
    .x_funct3     (x_funct3),
    .x_op         (x_op),
    .x_status     (x_status),
    .wb_we        (wb_we),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .redirect     (redirect),
    .target       (target),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .halt         (halt),
    .wb_we_q      (wb_we),
    .wb_rd_q      (wb_rd),
    .wb_data_q    (wb_data)
  );

endmodule

// ==== bench/riscv_pipeline_tb.sv ====
`timescale 1ns/100ps

module riscv_pipeline_tb;

  localparam int num_programs = 8;
  localparam int program_len  = 48;
  localparam int mem_words    = 64;
  localparam int clk_period   = 10;
  // each program gets its length plus reset and drain margin, three times over
  localparam int timeout_cycles = num_programs * (program_len + 20) * 3;

  typedef struct packed {
    rv_isa_pkg::word_t       pc;
    rv_isa_pkg::word_t       insn;
    pipe_pkg::cycle_status_e status;
    logic                    we;
    rv_isa_pkg::reg_idx_t    rd;
    rv_isa_pkg::word_t       data;
    logic                    halt;
  } trace_entry_t;

  logic                    clk = 1'b0;
  logic                    rst = 1'b1;
  rv_isa_pkg::word_t       insn = '0;
  rv_isa_pkg::word_t       pc;
  logic                    halt;
  rv_isa_pkg::word_t       trace_pc;
  rv_isa_pkg::word_t       trace_insn;
  pipe_pkg::cycle_status_e trace_status;
  logic                    wb_we;
  rv_isa_pkg::reg_idx_t    wb_rd;
  rv_isa_pkg::word_t       wb_data;

  rv_isa_pkg::word_t imem [0:mem_words-1];
  trace_entry_t      expected [$];
  logic [31:0]       rng_state = 32'd58;
  int                errors = 0;
  int                checks = 0;
  int                taken_count = 0;

  riscv_pipeline #(
    .reset_pc (32'h0)
  ) uut (
    .clk          (clk),
    .rst          (rst),
    .insn         (insn),
    .pc           (pc),
    .halt         (halt),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .wb_we        (wb_we),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data)
  );

  initial begin
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(timeout_cycles * clk_period);
    $display("timeout: the pipeline did not finish within %0d cycles", timeout_cycles);
    $display("Simulation failed");
    $finish;
  end

  // words past the program are ecall
  function automatic rv_isa_pkg::word_t read_imem(input rv_isa_pkg::word_t addr);
    if (addr < mem_words * 4) begin
      return imem[addr[7:2]];
    end
    return rv_isa_pkg::insn_ecall;
  endfunction

  // memory answers one cycle after the pc it sees
  always @(posedge clk) begin
    insn <= read_imem(pc);
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic rv_isa_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                                input rv_isa_pkg::word_t a,
                                                input rv_isa_pkg::word_t b);
    rv_isa_pkg::word_t r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input rv_isa_pkg::word_t a,
                                      input rv_isa_pkg::word_t b);
    case (f3)
      rv_isa_pkg::funct3_beq:  return a == b;
      rv_isa_pkg::funct3_bne:  return a != b;
      rv_isa_pkg::funct3_blt:  return $signed(a) < $signed(b);
      rv_isa_pkg::funct3_bge:  return $signed(a) >= $signed(b);
      rv_isa_pkg::funct3_bltu: return a < b;
      rv_isa_pkg::funct3_bgeu: return a >= b;
      default:                 return 1'b0;
    endcase
  endfunction

  // small register pool so dependences and x0 show up often
  task automatic build_program();
    logic [31:0]          r;
    logic [31:0]          r2;
    int                   kind;
    logic [2:0]           f3;
    logic [6:0]           f7;
    logic [11:0]          imm;
    logic [12:0]          boff;
    logic [20:0]          joff;
    logic [2:0]           br_f3 [6];
    rv_isa_pkg::reg_idx_t rd, rs1, rs2, prev_rd;
    br_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    prev_rd = 5'd1;
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = rv_isa_pkg::insn_ecall;
    end
    for (int i = 0; i < program_len - 1; i++) begin
      r    = next_rand();
      r2   = next_rand();
      kind = next_rand() % 10;
      rd   = {2'b0, r[2:0]};
      rs1  = r[3] ? prev_rd : {2'b0, r[6:4]};
      rs2  = r[7] ? prev_rd : {2'b0, r[10:8]};
      f3   = r[13:11];
      f7   = (r[14] && (f3 == 3'd0 || f3 == 3'd5)) ? rv_isa_pkg::funct7_alt :
                                                    rv_isa_pkg::funct7_base;
      if (kind < 3) begin
        imem[i] = {f7, rs2, rs1, f3, rd, rv_isa_pkg::opcode_op};
        prev_rd = rd;
      end else if (kind < 6) begin
        imm = r2[11:0];
        if (f3 == 3'd1) begin
          imm = {7'b0, r2[4:0]};
        end else if (f3 == 3'd5) begin
          imm = {f7, r2[4:0]};
        end
        imem[i] = {imm, rs1, f3, rd, rv_isa_pkg::opcode_op_imm};
        prev_rd = rd;
      end else if (kind == 6) begin
        imem[i] = {r2[19:0], rd, rv_isa_pkg::opcode_lui};
        prev_rd = rd;
      end else if (kind == 7) begin
        joff = 21'(4 * (2 + r2 % 7));
        imem[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, rv_isa_pkg::opcode_jal};
      end else begin
        boff = 13'(4 * (2 + r2 % 7));
        f3   = br_f3[r2[10:8] % 6];
        imem[i] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11],
                   rv_isa_pkg::opcode_branch};
      end
    end
  endtask

  // architectural run of the program, one entry per trace cycle
  task automatic build_expected();
    rv_isa_pkg::word_t    regs [32];
    rv_isa_pkg::word_t    model_pc, next_pc, w, a, b, result;
    rv_isa_pkg::reg_idx_t rd;
    logic [2:0]           f3;
    logic                 writes, taken;
    trace_entry_t         e;
    int                   steps;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    expected.delete();
    taken_count = 0;
    model_pc = '0;
    steps = 0;
    w = '0;
    while (w != rv_isa_pkg::insn_ecall && steps < 4 * program_len) begin
      w       = read_imem(model_pc);
      rd      = w[11:7];
      f3      = w[14:12];
      a       = regs[w[19:15]];
      b       = regs[w[24:20]];
      writes  = 1'b0;
      taken   = 1'b0;
      result  = '0;
      next_pc = model_pc + 32'd4;
      case (w[6:0])
        rv_isa_pkg::opcode_op: begin
          writes = 1'b1;
          result = alu_ref(f3, w[30], a, b);
        end
        rv_isa_pkg::opcode_op_imm: begin
          writes = 1'b1;
          result = alu_ref(f3, f3 == 3'd5 && w[30], a, {{20{w[31]}}, w[31:20]});
        end
        rv_isa_pkg::opcode_lui: begin
          writes = 1'b1;
          result = {w[31:12], 12'b0};
        end
        rv_isa_pkg::opcode_jal: begin
          writes  = 1'b1;
          result  = model_pc + 32'd4;
          taken   = 1'b1;
          next_pc = model_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        rv_isa_pkg::opcode_branch: begin
          taken = branch_ref(f3, a, b);
          if (taken) begin
            next_pc = model_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        default: ;
      endcase
      writes = writes && rd != 5'd0;
      if (writes) begin
        regs[rd] = result;
      end
      e = '{model_pc, w, pipe_pkg::cycle_no_stall, writes, rd, result,
            w == rv_isa_pkg::insn_ecall};
      expected.push_back(e);
      if (taken) begin
        taken_count++;
        e = '{32'h0, 32'h0, pipe_pkg::cycle_taken_branch, 1'b0, 5'd0, 32'h0, 1'b0};
        expected.push_back(e);
        expected.push_back(e);
      end
      model_pc = next_pc;
      steps++;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error: %s expected 0x%08h got 0x%08h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_entry(input trace_entry_t e);
    check_value("trace_status", trace_status, e.status);
    check_value("trace_pc", trace_pc, e.pc);
    check_value("trace_insn", trace_insn, e.insn);
    check_value("halt", halt, e.halt);
    check_value("wb_we", wb_we, e.we);
    if (e.we) begin
      check_value("wb_rd", wb_rd, e.rd);
      check_value("wb_data", wb_data, e.data);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    for (int c = 0; c < 10; c++) begin
      @(posedge clk);
      if (c < 9) begin
        @(negedge clk);
        check_value("trace_status", trace_status, pipe_pkg::cycle_reset);
        check_value("halt", halt, 1'b0);
        check_value("wb_we", wb_we, 1'b0);
      end
    end
    rst <= 1'b0;
  endtask

  // ends when the ecall entry has been compared
  task automatic run_program(input int idx);
    int           n_reset;
    int           n_cycles;
    int           err_before;
    trace_entry_t e;
    err_before = errors;
    n_reset = 0;
    n_cycles = 0;
    @(negedge clk);
    while (trace_status == pipe_pkg::cycle_reset && n_reset < 8) begin
      check_value("halt", halt, 1'b0);
      check_value("wb_we", wb_we, 1'b0);
      n_reset++;
      @(negedge clk);
    end
    checks++;
    assert (n_reset == 3) else begin
      $display("reset status lasted %0d cycles after reset fell instead of 3", n_reset);
      errors++;
    end
    while (expected.size() > 0) begin
      e = expected.pop_front();
      check_entry(e);
      n_cycles++;
      if (expected.size() > 0) begin
        @(negedge clk);
      end
    end
    $display("program %0d: %0d trace cycles, %0d taken, %0d errors",
             idx, n_cycles, taken_count, errors - err_before);
  endtask

  initial begin
    for (int p = 0; p < num_programs; p++) begin
      build_program();
      build_expected();
      apply_reset();
      run_program(p);
    end
    $display("%0d programs, %0d checks, %0d errors", num_programs, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
source/rv_isa_pkg.sv
source/pipe_pkg.sv
source/reg_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/alu.sv
source/execute_stage.sv
source/riscv_pipeline.sv
bench/riscv_pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: riscv_pipeline

sources:
  - files:
      - source/rv_isa_pkg.sv
      - source/pipe_pkg.sv
      - source/reg_file.sv
      - source/fetch_stage.sv
      - source/decode_stage.sv
      - source/alu.sv
      - source/execute_stage.sv
      - source/riscv_pipeline.sv
  - target: test
    files:
      - bench/riscv_pipeline_tb.sv
